/* data_mem.sv */
module data_mem (
    input  logic                                       clk,
    input  logic [3:0]                                 byte_en,
    input  logic [riscv_mem_pkg::dmem_addr_bits-1:0]   addr,
    input  logic [riscv_mem_pkg::xlen-1:0]             wdata,
    output logic [riscv_mem_pkg::xlen-1:0]             rdata
);

    logic [riscv_mem_pkg::xlen-1:0] mem [1 << riscv_mem_pkg::dmem_addr_bits];

    // Per-byte write
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (byte_en[i]) begin
                mem[addr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // Read returns the old word when a write hits the same address
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

/* load_extend.sv */
module load_extend (
    input  logic [riscv_mem_pkg::xlen-1:0]   word,
    input  logic [2:0]                       funct3,
    input  logic [1:0]                       addr_low,
    output logic [riscv_mem_pkg::xlen-1:0]   load_data
);

    logic [riscv_mem_pkg::xlen-1:0] shifted;

    // Bring the addressed lane down to bit 0
    assign shifted = word >> {addr_low, 3'b000};

    always_comb begin
        case (funct3)
            riscv_mem_pkg::funct3_byte: begin
                load_data = {{24{shifted[7]}}, shifted[7:0]};
            end
            riscv_mem_pkg::funct3_half: begin
                load_data = {{16{shifted[15]}}, shifted[15:0]};
            end
            riscv_mem_pkg::funct3_byte_u: begin
                load_data = {24'b0, shifted[7:0]};
            end
            riscv_mem_pkg::funct3_half_u: begin
                load_data = {16'b0, shifted[15:0]};
            end
            riscv_mem_pkg::funct3_word: begin
                load_data = shifted;
            end
            default: begin
                // Unknown size code, pass the raw word
                load_data = word;
            end
        endcase
    end

endmodule

/* mem_access_input.txt */
// test inst rs1_val rs2_val br_pred_correct uart_rx_data uart_rx_valid uart_tx_ready
// then expected-load flag and expected load_data; all hex except the decimal test id
5 0000A103 80000014 00000000 0 00 0 0 1 00000000
5 0000A103 8000001C 00000000 0 00 0 0 1 00000000
5 0000A103 80000020 00000000 0 00 0 0 1 00000000
5 0000A103 80000010 00000000 0 00 0 0 1 00000003
1 0020A023 10000000 DEADBEEF 0 00 0 0 0 00000000
1 0000A103 10000000 00000000 0 00 0 0 1 DEADBEEF
1 FE20AE23 30000104 12345678 0 00 0 0 0 00000000
1 0040A103 300000FC 00000000 0 00 0 0 1 12345678
2 0020A023 10000010 11223344 0 00 0 0 0 00000000
2 00208023 10000010 FFFFFFA0 0 00 0 0 0 00000000
2 00208023 10000011 123456B1 0 00 0 0 0 00000000
2 00208023 10000012 000000C2 0 00 0 0 0 00000000
2 00208023 10000013 DDDDDDD3 0 00 0 0 0 00000000
2 0000A103 10000010 00000000 0 00 0 0 1 D3C2B1A0
2 0020A023 10000020 55667788 0 00 0 0 0 00000000
2 00209023 10000020 ABCD8001 0 00 0 0 0 00000000
2 00209023 10000022 0000FEDC 0 00 0 0 0 00000000
2 0000A103 10000020 00000000 0 00 0 0 1 FEDC8001
2 00008103 10000010 00000000 0 00 0 0 1 FFFFFFA0
2 0000C103 10000011 00000000 0 00 0 0 1 000000B1
2 00009103 10000020 00000000 0 00 0 0 1 FFFF8001
2 0000D103 10000022 00000000 0 00 0 0 1 0000FEDC
2 00009103 30000102 00000000 0 00 0 0 1 00001234
3 0020A023 80000008 12345641 0 00 0 0 0 00000000
3 0000A103 80000004 00000000 0 9C 1 1 1 0000009C
3 0000A103 80000000 00000000 0 00 1 0 1 00000002
3 0000A103 80000000 00000000 0 00 0 1 1 00000001
4 0020A023 80000018 00000000 0 00 0 0 0 00000000
4 002081B3 00000000 00000000 1 00 0 0 0 00000000
4 00208063 00000000 00000000 1 00 0 0 0 00000000
4 00000013 00000000 00000000 1 00 0 0 0 00000000
4 00208063 00000000 00000000 0 00 0 0 0 00000000
4 00000013 00000000 00000000 0 00 0 0 0 00000000
4 00208063 00000000 00000000 1 00 0 0 0 00000000
4 0000A103 80000010 00000000 0 00 0 0 1 00000006
4 0000A103 80000014 00000000 0 00 0 0 1 00000005
4 0000A103 8000001C 00000000 0 00 0 0 1 00000003
4 0000A103 80000020 00000000 0 00 0 0 1 00000002

/* mem_access_unit.sv */
module mem_access_unit (
    input  logic                             clk,
    input  logic                             rst_n,
    input  riscv_mem_pkg::inst_word_t        inst,
    input  logic [riscv_mem_pkg::xlen-1:0]   rs1_val,
    input  logic [riscv_mem_pkg::xlen-1:0]   rs2_val,
    input  logic                             br_pred_correct,
    input  logic [7:0]                       uart_rx_data,
    input  logic                             uart_rx_valid,
    input  logic                             uart_tx_ready,
    output logic [riscv_mem_pkg::xlen-1:0]   load_data,
    output logic                             load_valid,
    output logic [7:0]                       uart_tx_data,
    output logic                             uart_tx_valid,
    output logic                             uart_rx_ready
);

    logic                           is_load;
    logic                           is_store;
    logic [riscv_mem_pkg::xlen-1:0] imm;
    logic [riscv_mem_pkg::xlen-1:0] addr;
    logic [3:0]                     region;
    logic                           in_dmem;
    logic                           in_mmio;
    logic                           dmem_store;
    logic                           mmio_store;
    logic                           mmio_load;
    logic [3:0]                     byte_en;
    logic [riscv_mem_pkg::xlen-1:0] wdata;
    logic [riscv_mem_pkg::xlen-1:0] dmem_rdata;
    logic [riscv_mem_pkg::xlen-1:0] mmio_rdata;
    logic                           counters_clear;
    logic [riscv_mem_pkg::xlen-1:0] cycles;
    logic [riscv_mem_pkg::xlen-1:0] insts;
    logic [riscv_mem_pkg::xlen-1:0] branches;
    logic [riscv_mem_pkg::xlen-1:0] correct;
    logic [2:0]                     funct3_q;
    logic [1:0]                     addr_low_q;
    logic                           mmio_sel_q;
    logic                           load_q;

    assign is_load  = (inst.load.opcode[6:2] == riscv_mem_pkg::opc_load);
    assign is_store = (inst.store.opcode[6:2] == riscv_mem_pkg::opc_store);

    // Effective address uses the S-type immediate for stores and I-type otherwise
    assign imm = is_store ? {{20{inst.store.imm_hi[6]}}, inst.store.imm_hi, inst.store.imm_lo}
                          : {{20{inst.load.imm[11]}}, inst.load.imm};
    assign addr = rs1_val + imm;

    assign region  = addr[31:28];
    assign in_dmem = (region == riscv_mem_pkg::region_dmem_a) ||
                     (region == riscv_mem_pkg::region_dmem_b);
    assign in_mmio = (region == riscv_mem_pkg::region_mmio);

    assign dmem_store = is_store && in_dmem;
    assign mmio_store = is_store && in_mmio;
    assign mmio_load  = is_load && in_mmio;

    assign uart_tx_data = rs2_val[7:0];

    store_align i_store_align (
        .dmem_store (dmem_store),
        .funct3     (inst.store.funct3),
        .addr_low   (addr[1:0]),
        .store_data (rs2_val),
        .byte_en    (byte_en),
        .wdata      (wdata)
    );

    data_mem i_data_mem (
        .clk     (clk),
        .byte_en (byte_en),
        .addr    (addr[riscv_mem_pkg::dmem_addr_bits+1:2]),
        .wdata   (wdata),
        .rdata   (dmem_rdata)
    );

    mmio_regs i_mmio_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .mmio_load      (mmio_load),
        .mmio_store     (mmio_store),
        .addr           (addr),
        .uart_rx_data   (uart_rx_data),
        .uart_rx_valid  (uart_rx_valid),
        .uart_tx_ready  (uart_tx_ready),
        .cycles         (cycles),
        .insts          (insts),
        .branches       (branches),
        .correct        (correct),
        .counters_clear (counters_clear),
        .uart_tx_valid  (uart_tx_valid),
        .uart_rx_ready  (uart_rx_ready),
        .rdata          (mmio_rdata)
    );

    perf_counters i_perf_counters (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst            (inst),
        .br_pred_correct (br_pred_correct),
        .counters_clear  (counters_clear),
        .cycles          (cycles),
        .insts           (insts),
        .branches        (branches),
        .correct         (correct)
    );

    // Load info travels alongside the memory read
    always_ff @(posedge clk) begin
        funct3_q   <= inst.load.funct3;
        addr_low_q <= addr[1:0];
        mmio_sel_q <= in_mmio;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_q <= 1'b0;
        end else begin
            load_q <= is_load;
        end
    end

    assign load_valid = load_q;

    load_extend i_load_extend (
        .word      (mmio_sel_q ? mmio_rdata : dmem_rdata),
        .funct3    (funct3_q),
        .addr_low  (addr_low_q),
        .load_data (load_data)
    );

    // Data memory lanes are written only for a dmem store and never beside an I/O strobe
    a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
        (byte_en != 4'b0000) |-> (dmem_store && !uart_tx_valid && !counters_clear))
        else $error("mem_access_unit: byte enables outside a data memory store");

endmodule

/* mmio_regs.sv */
module mmio_regs (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             mmio_load,
    input  logic                             mmio_store,
    input  logic [riscv_mem_pkg::xlen-1:0]   addr,
    input  logic [7:0]                       uart_rx_data,
    input  logic                             uart_rx_valid,
    input  logic                             uart_tx_ready,
    input  logic [riscv_mem_pkg::xlen-1:0]   cycles,
    input  logic [riscv_mem_pkg::xlen-1:0]   insts,
    input  logic [riscv_mem_pkg::xlen-1:0]   branches,
    input  logic [riscv_mem_pkg::xlen-1:0]   correct,
    output logic                             counters_clear,
    output logic                             uart_tx_valid,
    output logic                             uart_rx_ready,
    output logic [riscv_mem_pkg::xlen-1:0]   rdata
);

    logic [riscv_mem_pkg::xlen-1:0] rd_word;

    // Store-side strobes act in the same cycle
    assign uart_tx_valid  = mmio_store && (addr == riscv_mem_pkg::mmio_uart_tx);
    assign counters_clear = mmio_store && (addr == riscv_mem_pkg::mmio_counter_clear);

    always_comb begin
        case (addr)
            riscv_mem_pkg::mmio_uart_status: rd_word = {30'b0, uart_rx_valid, uart_tx_ready};
            riscv_mem_pkg::mmio_uart_rx:     rd_word = {24'b0, uart_rx_data};
            riscv_mem_pkg::mmio_cycles:      rd_word = cycles;
            riscv_mem_pkg::mmio_insts:       rd_word = insts;
            riscv_mem_pkg::mmio_branches:    rd_word = branches;
            riscv_mem_pkg::mmio_correct:     rd_word = correct;
            default:                         rd_word = '0;
        endcase
    end

    // Counts are captured before this cycle's increment
    always_ff @(posedge clk) begin
        rdata <= rd_word;
    end

    // Receive byte is consumed when the load result comes back
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            uart_rx_ready <= 1'b0;
        end else begin
            uart_rx_ready <= mmio_load && (addr == riscv_mem_pkg::mmio_uart_rx);
        end
    end

endmodule

/* perf_counters.sv */
module perf_counters (
    input  logic                             clk,
    input  logic                             rst_n,
    input  riscv_mem_pkg::inst_word_t        inst,
    input  logic                             br_pred_correct,
    input  logic                             counters_clear,
    output logic [riscv_mem_pkg::xlen-1:0]   cycles,
    output logic [riscv_mem_pkg::xlen-1:0]   insts,
    output logic [riscv_mem_pkg::xlen-1:0]   branches,
    output logic [riscv_mem_pkg::xlen-1:0]   correct
);

    logic [riscv_mem_pkg::xlen-1:0] count [4];
    logic [3:0]                     inc;
    logic                           is_branch;

    assign is_branch = (inst.load.opcode[6:2] == riscv_mem_pkg::opc_branch);

    // Index 0 cycles, 1 instructions, 2 branches, 3 correct predictions
    assign inc[0] = 1'b1;
    assign inc[1] = (inst != riscv_mem_pkg::nop_inst);
    assign inc[2] = is_branch;
    assign inc[3] = is_branch && br_pred_correct;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (!rst_n || counters_clear) begin
                count[i] <= '0;
            end else if (inc[i]) begin
                count[i] <= count[i] + 1'b1;
            end
        end
    end

    assign cycles   = count[0];
    assign insts    = count[1];
    assign branches = count[2];
    assign correct  = count[3];

    // Each counted event is a subset of the one counted before it
    a_count_order: assert property (@(posedge clk) disable iff (!rst_n)
        (correct <= branches) && (branches <= insts) && (insts <= cycles))
        else $error("perf_counters: counts out of order");

endmodule

/* riscv_mem_pkg.sv */
package riscv_mem_pkg;

    // Data and address width
    localparam int xlen = 32;

    // Major opcodes, instruction bits 6 to 2
    localparam logic [4:0] opc_load   = 5'b00000;
    localparam logic [4:0] opc_store  = 5'b01000;
    localparam logic [4:0] opc_branch = 5'b11000;

    // addi x0, x0, 0
    localparam logic [31:0] nop_inst = 32'h0000_0013;

    // Address map, top nibble
    localparam logic [3:0] region_dmem_a = 4'h1;
    localparam logic [3:0] region_dmem_b = 4'h3;
    localparam logic [3:0] region_mmio   = 4'h8;

    // Word index width of the data RAM
    localparam int dmem_addr_bits = 12;

    // Memory-mapped I/O registers
    localparam logic [31:0] mmio_uart_status   = 32'h8000_0000;
    localparam logic [31:0] mmio_uart_rx       = 32'h8000_0004;
    localparam logic [31:0] mmio_uart_tx       = 32'h8000_0008;
    localparam logic [31:0] mmio_cycles        = 32'h8000_0010;
    localparam logic [31:0] mmio_insts         = 32'h8000_0014;
    localparam logic [31:0] mmio_counter_clear = 32'h8000_0018;
    localparam logic [31:0] mmio_branches      = 32'h8000_001C;
    localparam logic [31:0] mmio_correct       = 32'h8000_0020;

    // Access size codes from funct3
    localparam logic [2:0] funct3_byte   = 3'b000;
    localparam logic [2:0] funct3_half   = 3'b001;
    localparam logic [2:0] funct3_word   = 3'b010;
    localparam logic [2:0] funct3_byte_u = 3'b100;
    localparam logic [2:0] funct3_half_u = 3'b101;

    // I-type view, used by loads
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } load_fields_t;

    // S-type view, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } store_fields_t;

    typedef union packed {
        load_fields_t  load;
        store_fields_t store;
    } inst_word_t;

endpackage

/* store_align.sv */
module store_align (
    input  logic                             dmem_store,
    input  logic [2:0]                       funct3,
    input  logic [1:0]                       addr_low,
    input  logic [riscv_mem_pkg::xlen-1:0]   store_data,
    output logic [3:0]                       byte_en,
    output logic [riscv_mem_pkg::xlen-1:0]   wdata
);

    // Lane enables per access size and offset
    always_comb begin
        byte_en = 4'b0000;
        if (dmem_store) begin
            case (funct3)
                riscv_mem_pkg::funct3_byte: begin
                    byte_en = 4'b0001 << addr_low;
                end
                riscv_mem_pkg::funct3_half: begin
                    // Only halfword-aligned offsets are legal
                    if (addr_low == 2'd0) begin
                        byte_en = 4'b0011;
                    end else if (addr_low == 2'd2) begin
                        byte_en = 4'b1100;
                    end
                end
                riscv_mem_pkg::funct3_word: begin
                    if (addr_low == 2'd0) begin
                        byte_en = 4'b1111;
                    end
                end
                default: begin
                    byte_en = 4'b0000;
                end
            endcase
        end
    end

    // Move the low bytes of rs2 up into the addressed lanes
    assign wdata = store_data << {addr_low, 3'b000};

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int period       = 100;
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Reset covers the first ten rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* tb_mem_access_unit.sv */
module tb_mem_access_unit;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 10;

    logic                           clk;
    logic                           rst_n;
    riscv_mem_pkg::inst_word_t      inst;
    logic [riscv_mem_pkg::xlen-1:0] rs1_val;
    logic [riscv_mem_pkg::xlen-1:0] rs2_val;
    logic                           br_pred_correct;
    logic [7:0]                     uart_rx_data;
    logic                           uart_rx_valid;
    logic                           uart_tx_ready;
    logic [riscv_mem_pkg::xlen-1:0] load_data;
    logic                           load_valid;
    logic [7:0]                     uart_tx_data;
    logic                           uart_tx_valid;
    logic                           uart_rx_ready;

    // One entry per vector line
    int          id_q[$];
    logic [31:0] inst_q[$];
    logic [31:0] rs1_q[$];
    logic [31:0] rs2_q[$];
    logic        brc_q[$];
    logic [7:0]  rx_data_q[$];
    logic        rx_valid_q[$];
    logic        tx_ready_q[$];
    logic        load_q[$];
    logic [31:0] data_q[$];

    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;
    bit vectors_loaded;

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_access_unit i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst            (inst),
        .rs1_val         (rs1_val),
        .rs2_val         (rs2_val),
        .br_pred_correct (br_pred_correct),
        .uart_rx_data    (uart_rx_data),
        .uart_rx_valid   (uart_rx_valid),
        .uart_tx_ready   (uart_tx_ready),
        .load_data       (load_data),
        .load_valid      (load_valid),
        .uart_tx_data    (uart_tx_data),
        .uart_tx_valid   (uart_tx_valid),
        .uart_rx_ready   (uart_rx_ready)
    );

    task automatic check_word(input string name, input logic [riscv_mem_pkg::xlen-1:0] exp,
                              input logic [riscv_mem_pkg::xlen-1:0] act);
        if (act !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_strobe(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, act);
            test_errors++;
        end
    endtask

    // rs1 plus the S-type immediate for stores, the I-type one for anything else
    function automatic logic [31:0] target_addr(input logic [31:0] word, input logic [31:0] base);
        logic [31:0] offset;
        if (word[6:0] == 7'b0100011) begin
            offset = {{20{word[31]}}, word[31:25], word[11:7]};
        end else begin
            offset = {{20{word[31]}}, word[31:20]};
        end
        return base + offset;
    endfunction

    task automatic read_vectors();
        int          fd;
        int          code;
        int          id;
        string       line;
        logic [31:0] f_inst;
        logic [31:0] f_rs1;
        logic [31:0] f_rs2;
        logic [31:0] f_brc;
        logic [31:0] f_rxd;
        logic [31:0] f_rxv;
        logic [31:0] f_txr;
        logic [31:0] f_ld;
        logic [31:0] f_data;
        fd = $fopen("mem_access_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file mem_access_input.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            // Skip column notes and blank lines
            if (line.len() < 2 || line.substr(0, 1) == "//") begin
                continue;
            end
            code = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h", id, f_inst, f_rs1, f_rs2,
                           f_brc, f_rxd, f_rxv, f_txr, f_ld, f_data);
            if (code == 10) begin
                id_q.push_back(id);
                inst_q.push_back(f_inst);
                rs1_q.push_back(f_rs1);
                rs2_q.push_back(f_rs2);
                brc_q.push_back(f_brc[0]);
                rx_data_q.push_back(f_rxd[7:0]);
                rx_valid_q.push_back(f_rxv[0]);
                tx_ready_q.push_back(f_txr[0]);
                load_q.push_back(f_ld[0]);
                data_q.push_back(f_data);
            end else if (code > 0) begin
                $display("A vector line could not be parsed and was skipped");
                errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_vector(input int i);
        inst            = inst_q[i];
        rs1_val         = rs1_q[i];
        rs2_val         = rs2_q[i];
        br_pred_correct = brc_q[i];
        uart_rx_data    = rx_data_q[i];
        uart_rx_valid   = rx_valid_q[i];
        uart_tx_ready   = tx_ready_q[i];
    endtask

    // Called one falling edge after the vector went in
    task automatic check_vector(input int i);
        logic [31:0] addr;
        logic        exp_tx;
        logic        exp_rx;
        addr   = target_addr(inst_q[i], rs1_q[i]);
        exp_tx = (inst_q[i][6:0] == 7'b0100011) && (addr == riscv_mem_pkg::mmio_uart_tx);
        exp_rx = (inst_q[i][6:0] == 7'b0000011) && (addr == riscv_mem_pkg::mmio_uart_rx);
        check_strobe("uart_tx_valid", exp_tx, uart_tx_valid);
        if (exp_tx) begin
            check_byte("uart_tx_data", rs2_q[i][7:0], uart_tx_data);
        end
        check_strobe("uart_rx_ready", exp_rx, uart_rx_ready);
        check_strobe("load_valid", load_q[i], load_valid);
        if (load_q[i]) begin
            check_word("load_data", data_q[i], load_data);
        end
    endtask

    task automatic report_test(input int id);
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %0d done, no mismatches", id);
        end else begin
            $display("Test %0d done, %0d mismatches", id, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    // Watchdog, four clock periods per vector on top of reset
    initial begin
        wait (vectors_loaded);
        #((inst_q.size() * 4 + reset_cycles + 4) * clk_period);
        $display("Timeout: the vectors did not complete in the expected time");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        inst            = riscv_mem_pkg::nop_inst;
        rs1_val         = '0;
        rs2_val         = '0;
        br_pred_correct = 1'b0;
        uart_rx_data    = 8'h00;
        uart_rx_valid   = 1'b0;
        uart_tx_ready   = 1'b0;
        errors          = 0;
        test_errors     = 0;
        tests_run       = 0;
        tests_failed    = 0;
        read_vectors();
        vectors_loaded = 1'b1;
        if (inst_q.size() == 0) begin
            $display("No test vectors were read");
            errors++;
        end
        wait (rst_n === 1'b1);
        // Idle inputs only, so every strobe must be low
        check_strobe("uart_tx_valid", 1'b0, uart_tx_valid);
        check_strobe("uart_rx_ready", 1'b0, uart_rx_ready);
        check_strobe("load_valid", 1'b0, load_valid);
        for (int i = 0; i < inst_q.size(); i++) begin
            drive_vector(i);
            @(negedge clk);
            check_vector(i);
            if (i == inst_q.size() - 1 || id_q[i + 1] != id_q[i]) begin
                report_test(id_q[i]);
            end
        end
        errors += test_errors;
        $display("%0d tests run, %0d failed, %0d errors in total",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* verilog.f */
riscv_mem_pkg.sv
store_align.sv
data_mem.sv
perf_counters.sv
mmio_regs.sv
load_extend.sv
mem_access_unit.sv
tb_clock_gen.sv
tb_mem_access_unit.sv
